// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert --timescale 1ns/10ps
TOP       := cpuTb
FILELIST  := filelist.f

OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
VECTORS   := sim/cpuVectors.txt
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(OBJDIR)/V%: $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJDIR) -o V$*

run: $(BIN) $(VECTORS)
	./$(BIN) | tee $(LOG)
	@grep -qx 'Test passed' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== filelist.f ====
logic/cpuPkg.sv
logic/phaseGen.sv
logic/fetchUnit.sv
logic/controlUnit.sv
logic/regFile.sv
logic/alu.sv
logic/cpuTop.sv
sim/cpuTb.sv

// ==== logic/alu.sv ====
// ALU with operand select, result register and zero and carry flags
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire                    clk,
  input  wire                    Reset,
  input  cpuPkg::ctrlT           ctrl,
  input  wire [cpuPkg::opW-1:0]  opcode,
  input  cpuPkg::dataT           op1,
  input  cpuPkg::dataT           regOp2,
  input  wire                    immFlag,
  input  cpuPkg::dataT           immValue,
  output cpuPkg::dataT           result,
  output logic                   zFlag,
  output logic                   cFlag
);

  cpuPkg::dataT            op2;
  logic [cpuPkg::dataW:0]  calc;  // Bit 8 becomes the carry

  assign op2 = immFlag ? immValue : regOp2;

  always_comb begin
    case (opcode)
      cpuPkg::opAdd: calc = {1'b0, op1} + {1'b0, op2};
      cpuPkg::opSub: calc = {1'b0, op1} - {1'b0, op2};  // Borrow lands in bit 8
      cpuPkg::opAnd: calc = {1'b0, op1 & op2};
      cpuPkg::opOr:  calc = {1'b0, op1 | op2};
      cpuPkg::opXor: calc = {1'b0, op1 ^ op2};
      cpuPkg::opShl: calc = {op1, 1'b0};  // Shifted-out bit is the carry
      cpuPkg::opShr: calc = {2'b00, op1[cpuPkg::dataW-1:1]};
      cpuPkg::opNot: calc = {1'b0, ~op1};
      cpuPkg::opSlt: begin
        calc = '0;
        calc[0] = (op1 < op2);
      end
      default: calc = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result and flags, loaded in T2
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      result <= '0;
    end else if (ctrl.aluSave) begin
      result <= calc[cpuPkg::dataW-1:0];
    end
  end

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      zFlag <= 1'b0;
      cFlag <= 1'b0;
    end else if (ctrl.flagSave) begin
      zFlag <= (calc[cpuPkg::dataW-1:0] == '0);
      cFlag <= calc[cpuPkg::dataW];
    end
  end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
// Phase-gated control decoder with conditional jumps
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
  input  cpuPkg::phaseT phase,
  input  cpuPkg::instrT instr,
  input  wire           zFlag,
  input  wire           cFlag,
  output cpuPkg::ctrlT  ctrl
);

  logic [cpuPkg::opW-1:0] opcode;
  logic                   aluOp;
  logic                   outOp;
  logic                   jumpTaken;

  assign opcode = instr.regForm.opcode;  // Same field in both forms

  //////////////////////////////////////////////////////////////////////
  // Per-opcode enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    aluOp     = 1'b0;
    outOp     = 1'b0;
    jumpTaken = 1'b0;
    case (opcode)
      cpuPkg::opAdd,
      cpuPkg::opSub,
      cpuPkg::opAnd,
      cpuPkg::opOr,
      cpuPkg::opXor,
      cpuPkg::opShl,
      cpuPkg::opShr,
      cpuPkg::opNot,
      cpuPkg::opSlt: begin
        aluOp = 1'b1;
      end
      cpuPkg::opOut: begin
        outOp = 1'b1;
      end
      cpuPkg::opJmp: begin
        jumpTaken = 1'b1;
      end
      cpuPkg::opJz: begin
        jumpTaken = zFlag;
      end
      cpuPkg::opJnz: begin
        jumpTaken = ~zFlag;
      end
      cpuPkg::opJc: begin
        jumpTaken = cFlag;
      end
      cpuPkg::opJnc: begin
        jumpTaken = ~cFlag;
      end
      default: begin
        aluOp = 1'b0;  // No-operation
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Gate enables by phase
  //////////////////////////////////////////////////////////////////////

  assign ctrl.instRead = phase.t0;
  assign ctrl.regRead  = phase.t1;
  assign ctrl.aluSave  = phase.t2 & aluOp;
  assign ctrl.flagSave = phase.t2 & aluOp;
  assign ctrl.outWrite = phase.t3 & outOp;
  assign ctrl.regWrite = phase.t4 & aluOp;
  assign ctrl.pcJump   = phase.t4 & jumpTaken;
  assign ctrl.pcStep   = phase.t4 & ~jumpTaken;  // Default is next word

endmodule

`default_nettype wire

// ==== logic/cpuPkg.sv ====
// Core widths, opcodes, instruction union, phase and control structs
`default_nettype none

package cpuPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and basic types
  //////////////////////////////////////////////////////////////////////

  localparam int dataW    = 8;
  localparam int regAddrW = 4;
  localparam int pcW      = 8;
  localparam int opW      = 5;
  localparam int instrW   = 25;

  typedef logic [dataW-1:0]    dataT;
  typedef logic [regAddrW-1:0] regAddrT;
  typedef logic [pcW-1:0]      pcT;

  //////////////////////////////////////////////////////////////////////
  // Opcodes, anything not listed executes as a no-operation
  //////////////////////////////////////////////////////////////////////

  localparam logic [opW-1:0] opAdd = 5'd0;
  localparam logic [opW-1:0] opSub = 5'd1;
  localparam logic [opW-1:0] opAnd = 5'd2;
  localparam logic [opW-1:0] opOr  = 5'd3;
  localparam logic [opW-1:0] opXor = 5'd4;
  localparam logic [opW-1:0] opShl = 5'd5;
  localparam logic [opW-1:0] opShr = 5'd6;
  localparam logic [opW-1:0] opNot = 5'd7;
  localparam logic [opW-1:0] opSlt = 5'd8;
  localparam logic [opW-1:0] opJc  = 5'd16;  // Jump if carry
  localparam logic [opW-1:0] opJnc = 5'd17;
  localparam logic [opW-1:0] opJmp = 5'd18;
  localparam logic [opW-1:0] opOut = 5'd21;
  localparam logic [opW-1:0] opJz  = 5'd27;  // Jump if zero
  localparam logic [opW-1:0] opJnz = 5'd28;

  //////////////////////////////////////////////////////////////////////
  // Instruction word, two views of the same 25 bits
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [opW-1:0] opcode;
    regAddrT        destin;
    regAddrT        source1;
    regAddrT        source2;
    logic [7:0]     unused;
  } instrRegT;

  // immFlag shares bit 8 with the low bit of source2
  typedef struct packed {
    logic [opW-1:0] opcode;
    regAddrT        destin;
    regAddrT        source1;
    logic [2:0]     pad;
    logic           immFlag;
    dataT           immValue;  // Operand or jump target
  } instrImmT;

  typedef union packed {
    instrRegT regForm;
    instrImmT immForm;
  } instrT;

  typedef struct packed {
    logic t0;
    logic t1;
    logic t2;
    logic t3;
    logic t4;
  } phaseT;

  typedef struct packed {
    logic instRead;
    logic regRead;
    logic aluSave;
    logic flagSave;
    logic outWrite;
    logic regWrite;
    logic pcJump;
    logic pcStep;
  } ctrlT;

endpackage

`default_nettype wire

// ==== logic/cpuTop.sv ====
// Processor top level with output port register
`timescale 1ns/10ps
`default_nettype none

module cpuTop #(
  parameter int numRegs = 16
) (
  input  wire           clk,
  input  wire           Reset,
  input  cpuPkg::instrT instrIn,
  output cpuPkg::pcT    progAddr,
  output cpuPkg::dataT  outPort,
  output logic          outValid
);

  cpuPkg::phaseT phase;
  cpuPkg::ctrlT  ctrl;
  cpuPkg::instrT instr;
  cpuPkg::dataT  rdData1;
  cpuPkg::dataT  rdData2;
  cpuPkg::dataT  result;
  logic          zFlag;
  logic          cFlag;

  phaseGen phaseGen_i (
    .clk   (clk),
    .Reset (Reset),
    .phase (phase)
  );

  fetchUnit fetchUnit_i (
    .clk      (clk),
    .Reset    (Reset),
    .ctrl     (ctrl),
    .instrIn  (instrIn),
    .progAddr (progAddr),
    .instr    (instr)
  );

  controlUnit controlUnit_i (
    .phase (phase),
    .instr (instr),
    .zFlag (zFlag),
    .cFlag (cFlag),
    .ctrl  (ctrl)
  );

  regFile #(
    .numRegs (numRegs)
  ) regFile_i (
    .clk     (clk),
    .Reset   (Reset),
    .ctrl    (ctrl),
    .wrAddr  (instr.regForm.destin),
    .rdAddr1 (instr.regForm.source1),
    .rdAddr2 (instr.regForm.source2),
    .wrData  (result),
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  alu alu_i (
    .clk      (clk),
    .Reset    (Reset),
    .ctrl     (ctrl),
    .opcode   (instr.regForm.opcode),
    .op1      (rdData1),
    .regOp2   (rdData2),
    .immFlag  (instr.immForm.immFlag),
    .immValue (instr.immForm.immValue),
    .result   (result),
    .zFlag    (zFlag),
    .cFlag    (cFlag)
  );

  //////////////////////////////////////////////////////////////////////
  // Output port, loaded in T3 and flagged valid during T4
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      outPort  <= '0;
      outValid <= 1'b0;
    end else begin
      outValid <= ctrl.outWrite;  // One-cycle pulse
      if (ctrl.outWrite) begin
        outPort <= rdData1;
      end
    end
  end

  // Write-back only in T4
  regWriteInT4: assert property (@(posedge clk) disable iff (Reset)
    ctrl.regWrite |-> phase.t4);

endmodule

`default_nettype wire

// ==== logic/fetchUnit.sv ====
// Program counter and instruction register
`timescale 1ns/10ps
`default_nettype none

module fetchUnit (
  input  wire           clk,
  input  wire           Reset,
  input  cpuPkg::ctrlT  ctrl,
  input  cpuPkg::instrT instrIn,
  output cpuPkg::pcT    progAddr,
  output cpuPkg::instrT instr
);

  cpuPkg::pcT pc;

  //////////////////////////////////////////////////////////////////////
  // Program counter, updated in T4
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      pc <= '0;
    end else if (ctrl.pcJump) begin
      pc <= instr.immForm.immValue;  // Jump target
    end else if (ctrl.pcStep) begin
      pc <= pc + cpuPkg::pcT'(1);
    end
  end

  assign progAddr = pc;

  //////////////////////////////////////////////////////////////////////
  // Instruction register, loaded at end of T0
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      instr <= '0;
    end else if (ctrl.instRead) begin
      instr <= instrIn;
    end
  end

endmodule

`default_nettype wire

// ==== logic/phaseGen.sv ====
// Five-phase timing generator T0 to T4
`timescale 1ns/10ps
`default_nettype none

module phaseGen (
  input  wire           clk,
  input  wire           Reset,
  output cpuPkg::phaseT phase
);

  logic [2:0] count;

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      count <= 3'd7;  // Idle, no phase active
    end else if (count >= 3'd4) begin
      count <= 3'd0;  // Wrap after T4, also leaves idle
    end else begin
      count <= count + 3'd1;
    end
  end

  assign phase.t0 = (count == 3'd0);
  assign phase.t1 = (count == 3'd1);
  assign phase.t2 = (count == 3'd2);
  assign phase.t3 = (count == 3'd3);
  assign phase.t4 = (count == 3'd4);

  // Once running the phase stays one-hot for good
  phaseOneHot: assert property (@(posedge clk) disable iff (Reset)
    $onehot(phase) |=> $onehot(phase));

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
// Register file, one write port and two registered read ports
`timescale 1ns/10ps
`default_nettype none

module regFile #(
  parameter int numRegs = 16
) (
  input  wire             clk,
  input  wire             Reset,
  input  cpuPkg::ctrlT    ctrl,
  input  cpuPkg::regAddrT wrAddr,
  input  cpuPkg::regAddrT rdAddr1,
  input  cpuPkg::regAddrT rdAddr2,
  input  cpuPkg::dataT    wrData,
  output cpuPkg::dataT    rdData1,
  output cpuPkg::dataT    rdData2
);

  cpuPkg::dataT regs [numRegs];

  // Write in T4
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.regWrite && int'(wrAddr) < numRegs) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Read ports latch in T1
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      rdData1 <= '0;
      rdData2 <= '0;
    end else if (ctrl.regRead) begin
      rdData1 <= (int'(rdAddr1) < numRegs) ? regs[rdAddr1] : '0;
      rdData2 <= (int'(rdAddr2) < numRegs) ? regs[rdAddr2] : '0;
    end
  end

  // Written register must exist when fewer than 16 are built
  writeInRange: assert property (@(posedge clk) disable iff (Reset)
    ctrl.regWrite |-> int'(wrAddr) < numRegs);

endmodule

`default_nettype wire

// ==== sim/cpuTb.sv ====
// Testbench with clock, reset, program memory playback, output checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

  localparam int clkPeriod   = 20;
  localparam int resetCycles = 5;
  localparam int memDepth    = 256;
  localparam int instrCycles = 5;
  localparam logic [cpuPkg::opW-1:0] fillOp = 5'd31;  // Unused opcode, runs as no-operation

  logic          clk      = 1'b0;
  logic          Reset    = 1'b1;
  cpuPkg::instrT instrIn  = '0;
  cpuPkg::pcT    progAddr;
  cpuPkg::dataT  outPort;
  logic          outValid;

  logic [cpuPkg::instrW-1:0] progMem [memDepth];
  cpuPkg::dataT              expected [$];
  cpuPkg::instrT             prevWord;
  cpuPkg::dataT              expVal;
  cpuPkg::pcT                lastPc     = '0;
  logic                      prevValid  = 1'b0;
  logic                      seenValid  = 1'b0;
  logic                      loaded     = 1'b0;
  logic                      halted     = 1'b0;
  int                        numWords   = 0;
  int                        haltAddr   = -1;
  int                        errors     = 0;
  int                        cycle      = 0;
  int                        outCount   = 0;
  int                        lastChange = -1;
  int                        lastValid  = -1;

  cpuTop #(
    .numRegs (16)
  ) dut_i (
    .clk      (clk),
    .Reset    (Reset),
    .instrIn  (instrIn),
    .progAddr (progAddr),
    .outPort  (outPort),
    .outValid (outValid)
  );

  always #(clkPeriod / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] want,
                            input logic [31:0] got);
    if (got !== want) begin
      $display("MISMATCH %s: expected %0h, actual %0h", name, want, got);
      errors++;
    end
  endtask

  function automatic logic isCondJump(input logic [cpuPkg::opW-1:0] op);
    return op == cpuPkg::opJz || op == cpuPkg::opJnz ||
           op == cpuPkg::opJc || op == cpuPkg::opJnc;
  endfunction

  task automatic loadVectors();
    int               fd;
    int               n;
    logic [7:0]       tag;
    logic [31:0]      addr;
    logic [31:0]      word;
    logic [8*128-1:0] line;
    logic             done;
    done = 1'b0;
    fd = $fopen("sim/cpuVectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vectors file sim/cpuVectors.txt");
      errors++;
    end else begin
      while (!done) begin
        if ($fscanf(fd, " %c", tag) != 1) begin
          done = 1'b1;
        end else if (tag == "P" && $fscanf(fd, "%h %h", addr, word) == 2) begin
          progMem[addr[7:0]] = word[cpuPkg::instrW-1:0];
          numWords++;
          if (word[24:20] == cpuPkg::opJmp && word[7:0] == addr[7:0]) begin
            haltAddr = int'(addr[7:0]);  // Jump to itself
          end
        end else if (tag == "E" && $fscanf(fd, "%h", word) == 1) begin
          expected.push_back(word[7:0]);
        end else begin
          n = $fgets(line, fd);  // Comment line
        end
      end
      $fclose(fd);
    end
  endtask

  // One falling edge worth of output checks
  task automatic sampleCycle();
    if (Reset) begin
      checkValue("reset outValid", 32'(0), 32'(outValid));
      checkValue("reset outPort", 32'(0), 32'(outPort));
      checkValue("reset progAddr", 32'(0), 32'(progAddr));
    end else begin
      if (cycle == resetCycles + 1) begin
        checkValue("progAddr after reset", 32'(0), 32'(progAddr));
      end
      if (!seenValid && !outValid) begin
        checkValue("outPort before first output", 32'(0), 32'(outPort));
      end
      checkValue("outValid width", 32'(0), 32'(outValid & prevValid));
      prevValid = outValid;
      if (outValid) begin
        seenValid = 1'b1;
        if (expected.size() == 0) begin
          $display("Output %0h at cycle %0d has no expected value left", outPort, cycle);
          errors++;
        end else begin
          expVal = expected.pop_front();
          checkValue($sformatf("output %0d", outCount), 32'(expVal), 32'(outPort));
        end
        if (lastValid >= 0) begin
          checkValue("output spacing", 32'(0), 32'((cycle - lastValid) % instrCycles));
        end
        lastValid = cycle;
        outCount++;
      end
      if (progAddr != lastPc) begin
        prevWord = progMem[lastPc];
        if (prevWord.regForm.opcode == cpuPkg::opJmp) begin
          checkValue("jump target", 32'(prevWord.immForm.immValue), 32'(progAddr));
        end else if (!(isCondJump(prevWord.regForm.opcode) &&
                       progAddr == prevWord.immForm.immValue)) begin
          checkValue("pc step", 32'(cpuPkg::pcT'(lastPc + 8'd1)), 32'(progAddr));
        end
        if (lastChange >= 0) begin
          checkValue("instruction length", 32'(instrCycles), 32'(cycle - lastChange));
        end
        lastChange = cycle;
        lastPc     = progAddr;
      end else if (int'(progAddr) == haltAddr && cycle - lastChange >= instrCycles) begin
        halted = 1'b1;  // Final jump ran and stayed put
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    for (int a = 0; a < memDepth; a++) begin
      progMem[a] = {fillOp, 12'h000, a[7:0]};
    end
    loadVectors();
    loaded = 1'b1;
    if (haltAddr < 0) begin
      $display("The program has no jump to itself, so it never ends");
      errors++;
    end
    while (!halted && haltAddr >= 0) begin
      @(negedge clk);
      cycle++;
      sampleCycle();
      if (cycle == resetCycles) begin
        Reset = 1'b0;
      end
      instrIn = progMem[progAddr];  // Program memory read
    end
    if (expected.size() != 0) begin
      $display("%0d expected output values were never produced", expected.size());
      errors++;
    end
    $display("Errors: %0d, outputs checked: %0d", errors, outCount);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #(instrCycles * clkPeriod * 4 * numWords + resetCycles * clkPeriod);
    $display("Run timed out before the program reached its final jump");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/cpuVectors.txt ====
# P <address> <instruction word>, both hex: program memory contents
# E <value>, hex: next outPort value expected while outValid is high
# Load r2 = B5 and r4 = 6C by immediate adds to r0
P 00 00201B5
P 01 004016C
# Register form, r6 = r2 op r4, then out r6
P 02 0062400
P 03 1506000
E 21
P 04 0162400
P 05 1506000
E 49
P 06 0262400
P 07 1506000
E 24
P 08 0362400
P 09 1506000
E FD
P 0A 0462400
P 0B 1506000
E D9
P 0C 0562400
P 0D 1506000
E 6A
P 0E 0662400
P 0F 1506000
E 5A
P 10 0762400
P 11 1506000
E 4A
P 12 0862400
P 13 1506000
E 00
# Immediate form, r10 = r4 op A3, then out r10
P 14 00A41A3
P 15 150A000
E 0F
P 16 01A41A3
P 17 150A000
E C9
P 18 02A41A3
P 19 150A000
E 20
P 1A 03A41A3
P 1B 150A000
E EF
P 1C 04A41A3
P 1D 150A000
E CF
P 1E 05A41A3
P 1F 150A000
E D8
P 20 06A41A3
P 21 150A000
E 36
P 22 07A41A3
P 23 150A000
E 93
P 24 08A41A3
P 25 150A000
E 01
# Sub to zero, jz taken skips out r2, jnz falls through to out r8
P 26 01821B5
P 27 1B00029
P 28 1502000
P 29 1C0002B
P 2A 1508000
E 00
# Sub with borrow, jnc falls through
P 2B 0184200
P 2C 110002E
P 2D 1508000
E B7
# Add with carry, jc taken skips out r2
P 2E 0082200
P 2F 1000031
P 30 1502000
P 31 1508000
E 6A
# And clears carry, jc falls through
P 32 028210F
P 33 1000035
P 34 1508000
E 05
# Jump to itself ends the program
P 35 1200035
